// File: rtl/mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// first fetch address after reset
`define MIPS_RESET_VECTOR 32'hBFC00000

// executing from this address stops the core
`define MIPS_HALT_ADDR 32'h00000000

// register indices with a fixed role
`define MIPS_REG_V0 5'd2
`define MIPS_REG_RA 5'd31

`endif

// File: rtl/mips_pkg.sv
package mips_pkg;

    // primary opcodes, instr[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'd0,  OP_REGIMM = 6'd1,  OP_J     = 6'd2,  OP_JAL   = 6'd3,
        OP_BEQ     = 6'd4,  OP_BNE    = 6'd5,  OP_BLEZ  = 6'd6,  OP_BGTZ  = 6'd7,
        OP_ADDI    = 6'd8,  OP_ADDIU  = 6'd9,  OP_SLTI  = 6'd10, OP_SLTIU = 6'd11,
        OP_ANDI    = 6'd12, OP_ORI    = 6'd13, OP_XORI  = 6'd14, OP_LUI   = 6'd15,
        OP_LB      = 6'd32, OP_LH     = 6'd33, OP_LW    = 6'd35, OP_LBU   = 6'd36,
        OP_LHU     = 6'd37, OP_SB     = 6'd40, OP_SH    = 6'd41, OP_SW    = 6'd43
    } opcode_t;

    // function codes under SPECIAL, instr[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'd0,  FN_SRL   = 6'd2,  FN_SRA  = 6'd3,  FN_SLLV  = 6'd4,
        FN_SRLV = 6'd6,  FN_SRAV  = 6'd7,  FN_JR   = 6'd8,  FN_JALR  = 6'd9,
        FN_MFHI = 6'd16, FN_MTHI  = 6'd17, FN_MFLO = 6'd18, FN_MTLO  = 6'd19,
        FN_MULT = 6'd24, FN_MULTU = 6'd25, FN_DIV  = 6'd26, FN_DIVU  = 6'd27,
        FN_ADD  = 6'd32, FN_ADDU  = 6'd33, FN_SUB  = 6'd34, FN_SUBU  = 6'd35,
        FN_AND  = 6'd36, FN_OR    = 6'd37, FN_XOR  = 6'd38, FN_NOR   = 6'd39,
        FN_SLT  = 6'd42, FN_SLTU  = 6'd43
    } funct_t;

    // rt field under REGIMM
    typedef enum logic [4:0] {
        RI_BLTZ   = 5'd0,
        RI_BGEZ   = 5'd1,
        RI_BLTZAL = 5'd16,
        RI_BGEZAL = 5'd17
    } regimm_t;

    // two cycles per instruction
    typedef enum logic {
        FETCH = 1'b0,
        EXEC  = 1'b1
    } cpu_state_t;

endpackage

// File: rtl/mips_regfile.sv
`include "mips_params.svh"

module mips_regfile (
    input  logic        clk,
    input  logic        reset,
    input  logic        clk_enable,
    input  logic [4:0]  read_index_a,
    input  logic [4:0]  read_index_b,
    input  logic        write_enable,
    input  logic [4:0]  write_index,
    input  logic [31:0] write_data,
    output logic [31:0] read_data_a,
    output logic [31:0] read_data_b,
    output logic [31:0] register_v0
);

    logic [31:0] regs [32];

    // $zero is never written, so it reads back as 0 after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (clk_enable && write_enable && write_index != 5'd0) begin
            regs[write_index] <= write_data;
        end
    end

    // reads see the old value in the write cycle
    assign read_data_a = regs[read_index_a];
    assign read_data_b = regs[read_index_b];

    assign register_v0 = regs[`MIPS_REG_V0];

endmodule

// File: rtl/mips_alu.sv
module mips_alu import mips_pkg::*; (
    input  logic [31:0] op_a,
    input  logic [31:0] op_b,
    input  logic [31:0] instr_word,
    output logic [31:0] result,
    output logic [31:0] hi,
    output logic [31:0] lo,
    output logic [31:0] eff_addr,
    output logic        branch_taken
);

    opcode_t     opcode;
    funct_t      funct;
    regimm_t     rt_code;
    logic [4:0]  shamt;
    logic [31:0] imm_sext;
    logic [31:0] imm_zext;
    logic [63:0] prod_s;
    logic [63:0] prod_u;
    logic [31:0] quot_s;
    logic [31:0] rem_s;
    logic [31:0] quot_u;
    logic [31:0] rem_u;

    assign opcode   = opcode_t'(instr_word[31:26]);
    assign funct    = funct_t'(instr_word[5:0]);
    assign rt_code  = regimm_t'(instr_word[20:16]);
    assign shamt    = instr_word[10:6];
    assign imm_sext = {{16{instr_word[15]}}, instr_word[15:0]};
    assign imm_zext = {16'd0, instr_word[15:0]};

    assign eff_addr = op_a + imm_sext;

    assign prod_s = $signed(op_a) * $signed(op_b);
    assign prod_u = op_a * op_b;

    // divide by zero is undefined on MIPS, give zeros
    always_comb begin
        if (op_b == 32'd0) begin
            quot_s = '0;
            rem_s  = '0;
            quot_u = '0;
            rem_u  = '0;
        end else begin
            quot_s = $signed(op_a) / $signed(op_b);
            rem_s  = $signed(op_a) % $signed(op_b);
            quot_u = op_a / op_b;
            rem_u  = op_a % op_b;
        end
    end

    always_comb begin
        result = '0;
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FN_SLL:          result = op_b << shamt;
                    FN_SRL:          result = op_b >> shamt;
                    FN_SRA:          result = $signed(op_b) >>> shamt;
                    FN_SLLV:         result = op_b << op_a[4:0];
                    FN_SRLV:         result = op_b >> op_a[4:0];
                    FN_SRAV:         result = $signed(op_b) >>> op_a[4:0];
                    FN_ADD, FN_ADDU: result = op_a + op_b;
                    FN_SUB, FN_SUBU: result = op_a - op_b;
                    FN_AND:          result = op_a & op_b;
                    FN_OR:           result = op_a | op_b;
                    FN_XOR:          result = op_a ^ op_b;
                    FN_NOR:          result = ~(op_a | op_b);
                    FN_SLT:          result = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
                    FN_SLTU:         result = (op_a < op_b) ? 32'd1 : 32'd0;
                    default:         result = '0;
                endcase
            end
            // no overflow trap, addi acts as addiu
            OP_ADDI, OP_ADDIU: result = op_a + imm_sext;
            OP_SLTI:  result = ($signed(op_a) < $signed(imm_sext)) ? 32'd1 : 32'd0;
            OP_SLTIU: result = (op_a < imm_sext) ? 32'd1 : 32'd0;
            OP_ANDI:  result = op_a & imm_zext;
            OP_ORI:   result = op_a | imm_zext;
            OP_XORI:  result = op_a ^ imm_zext;
            OP_LUI:   result = {instr_word[15:0], 16'd0};
            default:  result = '0;
        endcase
    end

    // mthi and mtlo both pass op_a, the core picks which one to write
    always_comb begin
        case (funct)
            FN_MULT:  {hi, lo} = prod_s;
            FN_MULTU: {hi, lo} = prod_u;
            FN_DIV: begin
                hi = rem_s;
                lo = quot_s;
            end
            FN_DIVU: begin
                hi = rem_u;
                lo = quot_u;
            end
            default: begin
                hi = op_a;
                lo = op_a;
            end
        endcase
    end

    always_comb begin
        case (opcode)
            OP_BEQ:  branch_taken = (op_a == op_b);
            OP_BNE:  branch_taken = (op_a != op_b);
            OP_BLEZ: branch_taken = ($signed(op_a) <= 0);
            OP_BGTZ: branch_taken = ($signed(op_a) > 0);
            OP_REGIMM: begin
                case (rt_code)
                    RI_BLTZ, RI_BLTZAL: branch_taken = op_a[31];
                    RI_BGEZ, RI_BGEZAL: branch_taken = !op_a[31];
                    default:            branch_taken = 1'b0;
                endcase
            end
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

// File: rtl/mips_mem_align.sv
module mips_mem_align import mips_pkg::*; (
    input  opcode_t     opcode,
    input  logic [31:0] eff_addr,
    input  logic [31:0] mem_word,
    input  logic [31:0] reg_word,
    output logic [31:0] load_data,
    output logic [31:0] store_data
);

    logic [1:0]  lane;
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    assign lane = eff_addr[1:0];

    // big endian, lane 0 is the top byte
    always_comb begin
        case (lane)
            2'd0:    sel_byte = mem_word[31:24];
            2'd1:    sel_byte = mem_word[23:16];
            2'd2:    sel_byte = mem_word[15:8];
            default: sel_byte = mem_word[7:0];
        endcase
    end

    assign sel_half = lane[1] ? mem_word[15:0] : mem_word[31:16];

    always_comb begin
        case (opcode)
            OP_LB:   load_data = {{24{sel_byte[7]}}, sel_byte};
            OP_LBU:  load_data = {24'd0, sel_byte};
            OP_LH:   load_data = {{16{sel_half[15]}}, sel_half};
            OP_LHU:  load_data = {16'd0, sel_half};
            default: load_data = mem_word;
        endcase
    end

    // partial stores merge into the word read during fetch
    always_comb begin
        store_data = mem_word;
        case (opcode)
            OP_SB: begin
                case (lane)
                    2'd0:    store_data[31:24] = reg_word[7:0];
                    2'd1:    store_data[23:16] = reg_word[7:0];
                    2'd2:    store_data[15:8]  = reg_word[7:0];
                    default: store_data[7:0]   = reg_word[7:0];
                endcase
            end
            OP_SH: begin
                if (lane[1]) begin
                    store_data[15:0] = reg_word[15:0];
                end else begin
                    store_data[31:16] = reg_word[15:0];
                end
            end
            default: store_data = reg_word;
        endcase
    end

endmodule

// File: rtl/mips_cpu_harvard.sv
`include "mips_params.svh"

module mips_cpu_harvard import mips_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        clk_enable,
    input  logic [31:0] instr_readdata,
    input  logic [31:0] data_readdata,
    output logic        active,
    output logic [31:0] register_v0,
    output logic [31:0] instr_address,
    output logic [31:0] data_address,
    output logic        data_write,
    output logic        data_read,
    output logic [31:0] data_writedata
);

    cpu_state_t  state;
    logic [31:0] pc;
    logic [31:0] delay_slot;
    logic [31:0] next_delay_slot;
    logic [31:0] hi_reg;
    logic [31:0] lo_reg;

    opcode_t     opcode;
    funct_t      funct;
    regimm_t     rt_code;
    logic        exec;
    logic        r_format;
    logic        alu_imm;
    logic        load_instr;
    logic        store_instr;
    logic        partial_store;
    logic        link_const;
    logic        link_reg;
    logic        j_imm;
    logic        j_reg;
    logic        mul_div;
    logic        hi_write;
    logic        lo_write;
    logic        mfhi;
    logic        mflo;
    logic        reg_write;
    logic [31:0] b_offset;

    logic [4:0]  reg_write_index;
    logic [31:0] reg_write_data;
    logic [31:0] reg_a;
    logic [31:0] reg_b;
    logic [31:0] alu_result;
    logic [31:0] alu_hi;
    logic [31:0] alu_lo;
    logic [31:0] eff_addr;
    logic        branch_taken;
    logic [31:0] load_data;

    assign opcode  = opcode_t'(instr_readdata[31:26]);
    assign funct   = funct_t'(instr_readdata[5:0]);
    assign rt_code = regimm_t'(instr_readdata[20:16]);

    assign exec = active && (state == EXEC);

    // decoded control levels
    assign r_format      = (opcode == OP_SPECIAL);
    assign alu_imm       = (instr_readdata[31:29] == 3'b001);
    assign load_instr    = (instr_readdata[31:29] == 3'b100);
    assign store_instr   = (instr_readdata[31:29] == 3'b101);
    assign partial_store = (opcode == OP_SB) || (opcode == OP_SH);
    assign j_imm         = (opcode == OP_J) || (opcode == OP_JAL);
    assign j_reg         = r_format && (funct == FN_JR || funct == FN_JALR);
    assign link_reg      = r_format && (funct == FN_JALR);
    assign link_const    = (opcode == OP_JAL) ||
                           (opcode == OP_REGIMM && (rt_code == RI_BLTZAL || rt_code == RI_BGEZAL));
    assign mul_div       = r_format && (funct == FN_MULT || funct == FN_MULTU ||
                                        funct == FN_DIV  || funct == FN_DIVU);
    assign hi_write      = mul_div || (r_format && funct == FN_MTHI);
    assign lo_write      = mul_div || (r_format && funct == FN_MTLO);
    assign mfhi          = r_format && (funct == FN_MFHI);
    assign mflo          = r_format && (funct == FN_MFLO);

    // jalr writes rd, so it is covered by r_format
    assign reg_write = (r_format && !hi_write && !lo_write && funct != FN_JR) ||
                       alu_imm || load_instr || link_const;

    assign reg_write_index = link_const ? `MIPS_REG_RA :
                             r_format   ? instr_readdata[15:11] : instr_readdata[20:16];

    // delay slot + 4 is the link's own address + 8
    always_comb begin
        if (link_const || link_reg) begin
            reg_write_data = delay_slot + 32'd4;
        end else if (mfhi) begin
            reg_write_data = hi_reg;
        end else if (mflo) begin
            reg_write_data = lo_reg;
        end else if (load_instr) begin
            reg_write_data = load_data;
        end else begin
            reg_write_data = alu_result;
        end
    end

    mips_regfile u_regfile (
        .clk          (clk),
        .reset        (reset),
        .clk_enable   (clk_enable),
        .read_index_a (instr_readdata[25:21]),
        .read_index_b (instr_readdata[20:16]),
        .write_enable (exec && reg_write),
        .write_index  (reg_write_index),
        .write_data   (reg_write_data),
        .read_data_a  (reg_a),
        .read_data_b  (reg_b),
        .register_v0  (register_v0)
    );

    mips_alu u_alu (
        .op_a         (reg_a),
        .op_b         (reg_b),
        .instr_word   (instr_readdata),
        .result       (alu_result),
        .hi           (alu_hi),
        .lo           (alu_lo),
        .eff_addr     (eff_addr),
        .branch_taken (branch_taken)
    );

    mips_mem_align u_mem_align (
        .opcode     (opcode),
        .eff_addr   (eff_addr),
        .mem_word   (data_readdata),
        .reg_word   (reg_b),
        .load_data  (load_data),
        .store_data (data_writedata)
    );

    // memory side
    assign data_address = {eff_addr[31:2], 2'b00};
    assign data_write   = exec && store_instr;
    assign data_read    = active && (load_instr || (partial_store && state == FETCH));

    // branch offsets are relative to the delay slot
    assign b_offset = {{14{instr_readdata[15]}}, instr_readdata[15:0], 2'b00};

    always_comb begin
        if (branch_taken) begin
            next_delay_slot = delay_slot + b_offset;
        end else if (j_imm) begin
            next_delay_slot = {delay_slot[31:28], instr_readdata[25:0], 2'b00};
        end else if (j_reg) begin
            next_delay_slot = reg_a;
        end else begin
            next_delay_slot = delay_slot + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= FETCH;
            pc         <= `MIPS_RESET_VECTOR;
            delay_slot <= `MIPS_RESET_VECTOR + 32'd4;
            active     <= 1'b1;
        end else if (clk_enable && active) begin
            if (state == FETCH) begin
                state <= EXEC;
            end else begin
                state      <= FETCH;
                pc         <= delay_slot;
                delay_slot <= next_delay_slot;
                if (pc == `MIPS_HALT_ADDR) begin
                    active <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clk_enable && exec) begin
            if (hi_write) begin
                hi_reg <= alu_hi;
            end
            if (lo_write) begin
                lo_reg <= alu_lo;
            end
        end
    end

    assign instr_address = pc;

endmodule

// File: tests/mips_tb_memory.sv
`include "mips_params.svh"

module mips_tb_memory (
    input  logic        clk,
    input  logic [31:0] instr_address,
    output logic [31:0] instr_readdata,
    input  logic [31:0] data_address,
    input  logic        data_write,
    input  logic        data_read,
    input  logic [31:0] data_writedata,
    output logic [31:0] data_readdata
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] rom [16];
    logic [31:0] ram [256];
    logic [31:0] rom_index;
    logic [31:0] read_hold;

    // ROM sits at the reset vector, everything else reads as nop
    assign rom_index      = (instr_address - `MIPS_RESET_VECTOR) >> 2;
    assign instr_readdata = (rom_index < 32'd16) ? rom[rom_index[3:0]] : 32'd0;

    // last word read stays on the bus while data_read is low
    always @(posedge clk) begin
        if (data_read) begin
            read_hold <= ram[data_address[9:2]];
        end
    end

    // the store merge in EXEC sees the word read during FETCH
    assign data_readdata = data_read ? ram[data_address[9:2]] : read_hold;

    always @(posedge clk) begin
        if (data_write) begin
            ram[data_address[9:2]] <= data_writedata;
        end
    end

endmodule

// File: tests/mips_cpu_sva.sv
module mips_cpu_sva import mips_pkg::*; (
    input logic        clk,
    input logic        reset,
    input logic        active,
    input logic        data_read,
    input logic        data_write,
    input logic [31:0] instr_address,
    input cpu_state_t  state
);
    timeunit 1ns;
    timeprecision 1ps;

    assert property (@(posedge clk) disable iff (reset) !(data_read && data_write))
        else $error("data_read and data_write high together");

    // a store only starts writing right after its fetch edge
    assert property (@(posedge clk) disable iff (reset)
                     $rose(data_write) |-> $past(state) == FETCH)
        else $error("data_write rose without a fetch edge before it");

    assert property (@(posedge clk) reset |=> !data_write && active)
        else $error("bad outputs after reset");

    assert property (@(posedge clk) disable iff (reset) instr_address[1:0] == 2'b00)
        else $error("instr_address not word aligned");

    // once halted, only reset wakes the core
    assert property (@(posedge clk) disable iff (reset) !active |=> !active)
        else $error("active rose without reset");

endmodule

bind mips_cpu_harvard mips_cpu_sva i_sva (
    .clk           (clk),
    .reset         (reset),
    .active        (active),
    .data_read     (data_read),
    .data_write    (data_write),
    .instr_address (instr_address),
    .state         (state)
);

// File: tests/mips_cpu_tb.sv
`include "mips_params.svh"

module mips_cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_TESTS = 7;
    localparam logic [31:0] BASE = `MIPS_RESET_VECTOR;
    // rows x 14 instr x 2 cycles x 2 stalls x 2 passes, plus reset and margin
    localparam int CYCLE_LIMIT = N_TESTS * 14 * 2 * 2 * 2 + N_TESTS * 2 * 10 + 200;
    localparam logic [4:0] ZR = 5'd0, V0 = 5'd2, T0 = 5'd8, T1 = 5'd9, T2 = 5'd10;
    localparam logic [4:0] T3 = 5'd11, T4 = 5'd12, T5 = 5'd13, RA = 5'd31;

    logic        clk, reset, clk_enable;
    logic        active, data_write, data_read;
    logic [31:0] register_v0, instr_address, instr_readdata;
    logic [31:0] data_address, data_writedata, data_readdata;

    string       names [N_TESTS];
    logic [31:0] prog [N_TESTS][12];
    logic [31:0] exp_v0 [N_TESTS];
    logic [31:0] chk_addr [N_TESTS];
    logic [31:0] exp_word [N_TESTS];
    int          cur_row, cur_len;
    int          cycles = 0;
    int          pass_count = 0, fail_count = 0;
    logic [31:0] rnd = 32'h16d3;

    mips_cpu_harvard i_dut (
        .clk(clk), .reset(reset), .clk_enable(clk_enable),
        .instr_readdata(instr_readdata), .data_readdata(data_readdata),
        .active(active), .register_v0(register_v0), .instr_address(instr_address),
        .data_address(data_address), .data_write(data_write), .data_read(data_read),
        .data_writedata(data_writedata)
    );

    mips_tb_memory i_mem (
        .clk(clk), .instr_address(instr_address), .instr_readdata(instr_readdata),
        .data_address(data_address), .data_write(data_write), .data_read(data_read),
        .data_writedata(data_writedata), .data_readdata(data_readdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped: core did not halt within %0d cycles", CYCLE_LIMIT);
            $display("Testbench failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // instruction encoders
    function automatic logic [31:0] rt_op(input logic [4:0] rs, rt, rd, sh, input int fn);
        return {6'd0, rs, rt, rd, sh, 6'(fn)};
    endfunction

    function automatic logic [31:0] it_op(input int op, input logic [4:0] rs, rt,
                                          input logic [15:0] imm);
        return {6'(op), rs, rt, imm};
    endfunction

    function automatic logic [31:0] jt_op(input int op, input logic [31:0] target);
        return {6'(op), target[27:2]};
    endfunction

    task automatic begin_row(input int r, input string name, input logic [31:0] v0,
                             input logic [31:0] addr, input logic [31:0] word);
        cur_row = r;
        cur_len = 0;
        names[r] = name;
        exp_v0[r] = v0;
        chk_addr[r] = addr;
        exp_word[r] = word;
        for (int i = 0; i < 12; i++) begin
            prog[r][i] = 32'd0;
        end
    endtask

    task automatic put(input logic [31:0] word);
        prog[cur_row][cur_len] = word;
        cur_len++;
    endtask

    // every program returns to address 0 and halts
    task automatic end_row();
        put(rt_op(ZR, ZR, ZR, 0, 8));
        put(32'd0);
    endtask

    task automatic build_table();
        begin_row(0, "alu", (32'h2468ACE6 ^ 32'h12345678) + 32'd1, 32'h0, 32'h0);
        put(it_op(9, ZR, T0, 16'd5));
        put(it_op(15, ZR, T1, 16'h1234));
        put(it_op(13, T1, T1, 16'h5678));
        put(rt_op(T1, T0, T2, 0, 35));
        put(rt_op(T0, T1, T3, 0, 42));
        put(rt_op(T3, T2, T4, 0, 4));
        put(rt_op(T4, T1, T5, 0, 38));
        put(rt_op(T5, T3, V0, 0, 33));
        end_row();

        // -21 from mult, -1 from div remainder, 0xfffffff9 / 3 from divu
        begin_row(1, "mult_div", 32'h55555553 - 32'd22, 32'h0, 32'h0);
        put(it_op(9, ZR, T0, 16'hFFF9));
        put(it_op(9, ZR, T1, 16'd3));
        put(rt_op(T0, T1, ZR, 0, 24));
        put(rt_op(ZR, ZR, T2, 0, 18));
        put(rt_op(T0, T1, ZR, 0, 26));
        put(rt_op(ZR, ZR, T3, 0, 16));
        put(rt_op(T0, T1, ZR, 0, 27));
        put(rt_op(ZR, ZR, T4, 0, 18));
        put(rt_op(T2, T3, T2, 0, 33));
        put(rt_op(T2, T4, V0, 0, 33));
        end_row();

        // multu hi is 1, then hi 2 and lo -1 moved in
        begin_row(2, "multu_mthi", 32'd2, 32'h0, 32'h0);
        put(it_op(9, ZR, T0, 16'hFFFF));
        put(it_op(9, ZR, T1, 16'd2));
        put(rt_op(T0, T1, ZR, 0, 25));
        put(rt_op(ZR, ZR, T2, 0, 16));
        put(rt_op(T1, ZR, ZR, 0, 17));
        put(rt_op(T0, ZR, ZR, 0, 19));
        put(rt_op(ZR, ZR, T3, 0, 16));
        put(rt_op(ZR, ZR, T4, 0, 18));
        put(rt_op(T2, T3, V0, 0, 33));
        put(rt_op(V0, T4, V0, 0, 33));
        end_row();

        // word 80f1f702: lb 0 -> -128, lbu 1 -> f1, lh 2 -> fffff702, lhu 0 -> 80f1
        begin_row(3, "loads", 32'hFFFFFF80 + 32'hF1 + 32'hFFFFF702 + 32'h80F1,
                  32'h100, 32'h80F1F702);
        put(it_op(15, ZR, T1, 16'h80F1));
        put(it_op(13, T1, T1, 16'hF702));
        put(it_op(43, ZR, T1, 16'h0100));
        put(it_op(32, ZR, T2, 16'h0100));
        put(it_op(36, ZR, T3, 16'h0101));
        put(it_op(33, ZR, T4, 16'h0102));
        put(it_op(37, ZR, T5, 16'h0100));
        put(rt_op(T2, T3, T2, 0, 33));
        put(rt_op(T4, T5, T4, 0, 33));
        put(rt_op(T2, T4, V0, 0, 33));
        end_row();

        begin_row(4, "partial_store", 32'hFFFFFFFE, 32'h200, 32'h11ABFFFE);
        put(it_op(15, ZR, T1, 16'h1122));
        put(it_op(13, T1, T1, 16'h3344));
        put(it_op(43, ZR, T1, 16'h0200));
        put(it_op(9, ZR, T2, 16'h00AB));
        put(it_op(40, ZR, T2, 16'h0201));
        put(it_op(9, ZR, T3, 16'hFFFE));
        put(it_op(41, ZR, T3, 16'h0202));
        put(it_op(32, ZR, V0, 16'h0203));
        end_row();

        // beq skips word 3, both delay slots run, bne falls through
        begin_row(5, "branches", 32'd1 + 32'd2 + 32'd4 + 32'd16, 32'h0, 32'h0);
        put(it_op(9, ZR, T0, 16'd1));
        put(it_op(4, ZR, ZR, 16'd2));
        put(it_op(9, T0, T0, 16'd2));
        put(it_op(9, T0, T0, 16'd100));
        put(it_op(5, T0, T0, 16'd2));
        put(it_op(9, T0, T0, 16'd4));
        put(it_op(9, T0, V0, 16'd16));
        end_row();

        // jal at word 0 links base+8, bgezal at word 4 links base+24
        begin_row(6, "links", 32'd16 + 32'd5, 32'h40, BASE + 32'd24);
        put(jt_op(3, BASE + 32'd12));
        put(it_op(9, ZR, T0, 16'd5));
        put(it_op(9, T0, T0, 16'd100));
        put(rt_op(RA, ZR, T1, 0, 33));
        put(it_op(1, ZR, 5'd17, 16'd1));
        put(rt_op(RA, T1, T1, 0, 35));
        put(it_op(43, ZR, RA, 16'h0040));
        put(rt_op(T1, T0, V0, 0, 33));
        end_row();
    endtask

    task automatic load_program(input int r);
        for (int i = 0; i < 16; i++) begin
            i_mem.rom[i] = (i < 12) ? prog[r][i] : 32'd0;
        end
        for (int i = 0; i < 256; i++) begin
            i_mem.ram[i] = 32'd0;
        end
    endtask

    task automatic run_test(input int r, input bit stall);
        int errors;
        logic [31:0] ram_word;
        errors = 0;
        load_program(r);
        @(negedge clk);
        reset = 1'b1;
        clk_enable = 1'b1;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        while (active !== 1'b0) begin
            if (stall) begin
                rnd = xorshift(rnd);
                clk_enable = rnd[0] | rnd[1];
            end
            @(negedge clk);
        end
        clk_enable = 1'b1;
        repeat (4) @(negedge clk);
        ram_word = i_mem.ram[chk_addr[r][9:2]];
        assert (register_v0 === exp_v0[r]) else begin
            $display("CHECK FAILED t=%0t register_v0 expected %h got %h",
                     $time, exp_v0[r], register_v0);
            errors++;
        end
        assert (ram_word === exp_word[r]) else begin
            $display("CHECK FAILED t=%0t ram[%h] expected %h got %h",
                     $time, chk_addr[r], exp_word[r], ram_word);
            errors++;
        end
        assert (active === 1'b0) else begin
            $display("core became active again after halting at t=%0t", $time);
            errors++;
        end
        if (errors == 0) begin
            pass_count++;
            $display("test %s stall=%0d: ok", names[r], stall);
        end else begin
            fail_count++;
            $display("test %s stall=%0d: %0d errors", names[r], stall, errors);
        end
    endtask

    initial begin
        reset = 1'b1;
        clk_enable = 1'b1;
        build_table();
        for (int p = 0; p < 2; p++) begin
            for (int r = 0; r < N_TESTS; r++) begin
                run_test(r, p[0]);
            end
        end
        $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+rtl
rtl/mips_pkg.sv
rtl/mips_regfile.sv
rtl/mips_alu.sv
rtl/mips_mem_align.sv
rtl/mips_cpu_harvard.sv
tests/mips_tb_memory.sv
tests/mips_cpu_sva.sv
tests/mips_cpu_tb.sv

// File: Bender.yml
package:
  name: mips_cpu_harvard

export_include_dirs:
  - rtl

sources:
  - rtl/mips_pkg.sv
  - rtl/mips_regfile.sv
  - rtl/mips_alu.sv
  - rtl/mips_mem_align.sv
  - rtl/mips_cpu_harvard.sv
  - target: test
    files:
      - tests/mips_tb_memory.sv
      - tests/mips_cpu_sva.sv
      - tests/mips_cpu_tb.sv
